/* Makefile */
# Verilator simulation of the load-store stage

VERILATOR ?= verilator
TOP       ?= tb_lsu_top
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TEST OK

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# status comes from the pass line, not the exit code
run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
lsu_pkg.sv
ls_ctrl.sv
lsu.sv
apb_data_ram.sv
lsu_top.sv
tb_lsu_top.sv

/* apb_data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module apb_data_ram (
    input  wire                  clk,
    input  wire                  arst_n_i,
    // apb slave
    input  wire                  psel_i,
    input  wire                  penable_i,
    input  wire                  pwrite_i,
    input  wire lsu_pkg::xlen_t  paddr_i,
    input  wire lsu_pkg::xlen_t  pwdata_i,
    input  wire lsu_pkg::strb_t  pstrb_i,
    output lsu_pkg::xlen_t       prdata_o,
    output logic                 pready_o,
    output logic                 pslverr_o
);

    // doubleword storage
    lsu_pkg::xlen_t    mem [lsu_pkg::RAM_WORDS];

    lsu_pkg::ram_idx_t idx;
    logic              in_range;
    logic              access;
    logic              wr_en;

    // word index from address bits 10..3
    assign idx      = paddr_i[lsu_pkg::RAM_AW+2:3];
    assign in_range = (paddr_i < lsu_pkg::RAM_BYTES);

    // second cycle of the transfer
    assign access = psel_i && penable_i;
    assign wr_en  = access && pwrite_i && in_range;

    // single-cycle memory, never stalls
    assign pready_o = 1'b1;
    // out of range in the access phase
    assign pslverr_o = access && !in_range;

    // whole word, lane selection is done by the master
    assign prdata_o = in_range ? mem[idx] : '0;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int w = 0; w < lsu_pkg::RAM_WORDS; w++) begin
                mem[w] <= '0;
            end
        end else if (wr_en) begin
            // strobed bytes only
            for (int b = 0; b < 8; b++) begin
                if (pstrb_i[b]) begin
                    mem[idx][8*b +: 8] <= pwdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* ls_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ls_ctrl (
    // current and previous instruction
    input  wire lsu_pkg::inst_t  instr_i,
    input  wire lsu_pkg::inst_t  instr_last_i,
    // register operand and write-back value of the previous instruction
    input  wire lsu_pkg::xlen_t  rs2_i,
    input  wire lsu_pkg::xlen_t  wb_data_i,
    // decoded operation
    output logic                 wren_o,
    output logic                 rden_o,
    output lsu_pkg::memop_t      memop_o,
    output lsu_pkg::xlen_t       wr_data_o
);

    logic cur_32b;
    logic last_32b;
    logic last_is_load;
    logic rs2_hit;
    logic fwd_en;

    // only full-length encodings count as memory ops
    assign cur_32b  = (instr_i[1:0] == lsu_pkg::OPC_LOW_32);
    assign last_32b = (instr_last_i[1:0] == lsu_pkg::OPC_LOW_32);

    // class from the major opcode
    assign wren_o = cur_32b && (instr_i[6:2] == lsu_pkg::OPC_STORE);
    assign rden_o = cur_32b && (instr_i[6:2] == lsu_pkg::OPC_LOAD);

    // funct3 carries width and signedness
    assign memop_o = instr_i[14:12];

    // load-to-store forwarding
    // previous load has not reached the register file yet
    assign last_is_load = last_32b && (instr_last_i[6:2] == lsu_pkg::OPC_LOAD);
    // rd of the load against rs2 of this instruction
    assign rs2_hit = (instr_i[24:20] == instr_last_i[11:7]);
    assign fwd_en  = last_is_load && rs2_hit;

    // store data, bypassed when the operand is stale
    assign wr_data_o = fwd_en ? wb_data_i : rs2_i;

endmodule

`default_nettype wire

/* lsu.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu (
    input  wire                  clk,
    input  wire                  arst_n_i,
    // request handshake
    input  wire                  valid_i,
    output logic                 ready_o,
    input  wire                  wren_i,
    input  wire                  rden_i,
    input  wire lsu_pkg::memop_t memop_i,
    input  wire lsu_pkg::xlen_t  addr_i,
    input  wire lsu_pkg::xlen_t  wr_data_i,
    // completion
    output logic                 done_o,
    output logic                 err_o,
    output lsu_pkg::xlen_t       ls_res_o,
    // apb master
    output logic                 psel_o,
    output logic                 penable_o,
    output logic                 pwrite_o,
    output lsu_pkg::xlen_t       paddr_o,
    output lsu_pkg::xlen_t       pwdata_o,
    output lsu_pkg::strb_t       pstrb_o,
    input  wire lsu_pkg::xlen_t  prdata_i,
    input  wire                  pready_i,
    input  wire                  pslverr_i
);

    lsu_pkg::lsu_state_e state_q;
    lsu_pkg::lsu_state_e state_d;

    logic            accept;
    logic            xfer_end;
    logic            misaligned;
    logic            bad_width;
    logic            req_err;
    lsu_pkg::strb_t  size_mask;
    lsu_pkg::strb_t  strb_lane;
    lsu_pkg::xlen_t  wdata_lane;
    lsu_pkg::xlen_t  rd_shift;
    lsu_pkg::xlen_t  load_val;

    // registered request
    logic            err_q;
    logic            wr_q;
    logic            rd_q;
    lsu_pkg::memop_t memop_q;
    lsu_pkg::xlen_t  addr_q;
    lsu_pkg::xlen_t  wdata_q;
    lsu_pkg::strb_t  strb_q;
    lsu_pkg::xlen_t  res_q;

    assign ready_o  = (state_q == lsu_pkg::IDLE);
    assign accept   = valid_i && ready_o;
    // last cycle of the access phase
    assign xfer_end = (state_q == lsu_pkg::ACCESS) && pready_i;

    // byte mask and alignment by access size
    always_comb begin
        case (memop_i[1:0])
            2'd0: begin
                size_mask  = 8'h01;
                misaligned = 1'b0;
            end
            2'd1: begin
                size_mask  = 8'h03;
                misaligned = addr_i[0];
            end
            2'd2: begin
                size_mask  = 8'h0f;
                misaligned = (addr_i[1:0] != 2'b00);
            end
            default: begin
                size_mask  = 8'hff;
                misaligned = (addr_i[2:0] != 3'b000);
            end
        endcase
    end

    // unsigned stores and ldu do not exist
    assign bad_width = (wren_i && memop_i[2]) || (rden_i && (&memop_i));
    assign req_err   = !(wren_i || rden_i) || misaligned || bad_width;

    // store data into its byte lanes, no strobes on reads
    assign wdata_lane = wr_data_i << {addr_i[2:0], 3'b000};
    assign strb_lane  = wren_i ? lsu_pkg::strb_t'(size_mask << addr_i[2:0]) : '0;

    // load extraction from the addressed lane
    assign rd_shift = prdata_i >> {addr_q[2:0], 3'b000};

    always_comb begin
        case (memop_q)
            lsu_pkg::MEMOP_B:  load_val = {{(lsu_pkg::XLEN-8){rd_shift[7]}}, rd_shift[7:0]};
            lsu_pkg::MEMOP_H:  load_val = {{(lsu_pkg::XLEN-16){rd_shift[15]}}, rd_shift[15:0]};
            lsu_pkg::MEMOP_W:  load_val = {{(lsu_pkg::XLEN-32){rd_shift[31]}}, rd_shift[31:0]};
            lsu_pkg::MEMOP_BU: load_val = {{(lsu_pkg::XLEN-8){1'b0}}, rd_shift[7:0]};
            lsu_pkg::MEMOP_HU: load_val = {{(lsu_pkg::XLEN-16){1'b0}}, rd_shift[15:0]};
            lsu_pkg::MEMOP_WU: load_val = {{(lsu_pkg::XLEN-32){1'b0}}, rd_shift[31:0]};
            default:           load_val = rd_shift;
        endcase
    end

    // sequencing
    always_comb begin
        state_d = state_q;
        case (state_q)
            lsu_pkg::IDLE: begin
                // rejected requests skip the bus
                if (accept) begin
                    state_d = req_err ? lsu_pkg::DONE : lsu_pkg::SETUP;
                end
            end
            lsu_pkg::SETUP: begin
                state_d = lsu_pkg::ACCESS;
            end
            lsu_pkg::ACCESS: begin
                // stall while the slave holds pready low
                if (pready_i) begin
                    state_d = lsu_pkg::DONE;
                end
            end
            default: begin
                state_d = lsu_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= lsu_pkg::IDLE;
            err_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            if (accept) begin
                err_q <= req_err;
            end else if (xfer_end) begin
                err_q <= pslverr_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr_q    <= wren_i;
            rd_q    <= rden_i;
            memop_q <= memop_i;
            addr_q  <= addr_i;
            wdata_q <= wdata_lane;
            strb_q  <= strb_lane;
            // stores and errors report zero
            res_q   <= '0;
        end else if (xfer_end && rd_q && !pslverr_i) begin
            res_q   <= load_val;
        end
    end

    assign done_o   = (state_q == lsu_pkg::DONE);
    assign err_o    = err_q;
    assign ls_res_o = res_q;

    // bus outputs come from registers, stable across wait states
    assign psel_o    = (state_q == lsu_pkg::SETUP) || (state_q == lsu_pkg::ACCESS);
    assign penable_o = (state_q == lsu_pkg::ACCESS);
    assign pwrite_o  = wr_q;
    assign paddr_o   = {addr_q[lsu_pkg::XLEN-1:3], 3'b000};
    assign pwdata_o  = wdata_q;
    assign pstrb_o   = strb_q;

endmodule

`default_nettype wire

/* lsu_pkg.sv */
`default_nettype none

package lsu_pkg;

    // data and address width
    localparam int XLEN     = 64;
    localparam int INST_LEN = 32;

    // major opcode, instruction bits 6..2
    localparam logic [4:0] OPC_LOAD  = 5'b00000;
    localparam logic [4:0] OPC_STORE = 5'b01000;
    // bits 1..0 of every 32-bit encoding
    localparam logic [1:0] OPC_LOW_32 = 2'b11;

    // funct3 width codes, shared by loads and stores
    localparam logic [2:0] MEMOP_B  = 3'b000;
    localparam logic [2:0] MEMOP_H  = 3'b001;
    localparam logic [2:0] MEMOP_W  = 3'b010;
    localparam logic [2:0] MEMOP_D  = 3'b011;
    localparam logic [2:0] MEMOP_BU = 3'b100;
    localparam logic [2:0] MEMOP_HU = 3'b101;
    localparam logic [2:0] MEMOP_WU = 3'b110;

    // data ram geometry, in doublewords
    localparam int RAM_WORDS = 256;
    localparam int RAM_AW    = 8;

    typedef logic [XLEN-1:0]     xlen_t;
    typedef logic [INST_LEN-1:0] inst_t;
    typedef logic [2:0]          memop_t;
    typedef logic [7:0]          strb_t;
    typedef logic [RAM_AW-1:0]   ram_idx_t;

    // first byte address past the ram
    localparam xlen_t RAM_BYTES = xlen_t'(RAM_WORDS * 8);

    // lsu sequencing, one access at a time
    typedef enum logic [1:0] {
        IDLE,
        SETUP,
        ACCESS,
        DONE
    } lsu_state_e;

endpackage

`default_nettype wire

/* lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
    input  wire                  clk,
    input  wire                  arst_n_i,
    // request
    input  wire                  valid_i,
    output logic                 ready_o,
    input  wire lsu_pkg::inst_t  instr_i,
    input  wire lsu_pkg::inst_t  instr_last_i,
    input  wire lsu_pkg::xlen_t  addr_i,
    input  wire lsu_pkg::xlen_t  rs2_i,
    input  wire lsu_pkg::xlen_t  wb_data_i,
    // completion
    output logic                 done_o,
    output logic                 err_o,
    output lsu_pkg::xlen_t       ls_res_o
);

    // decode to lsu
    logic            wren;
    logic            rden;
    lsu_pkg::memop_t memop;
    lsu_pkg::xlen_t  wr_data;

    // apb bus
    logic            psel;
    logic            penable;
    logic            pwrite;
    lsu_pkg::xlen_t  paddr;
    lsu_pkg::xlen_t  pwdata;
    lsu_pkg::strb_t  pstrb;
    lsu_pkg::xlen_t  prdata;
    logic            pready;
    logic            pslverr;

    ls_ctrl u_ls_ctrl (
        .instr_i      (instr_i),
        .instr_last_i (instr_last_i),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .wren_o       (wren),
        .rden_o       (rden),
        .memop_o      (memop),
        .wr_data_o    (wr_data)
    );

    lsu u_lsu (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .valid_i   (valid_i),
        .ready_o   (ready_o),
        .wren_i    (wren),
        .rden_i    (rden),
        .memop_i   (memop),
        .addr_i    (addr_i),
        .wr_data_i (wr_data),
        .done_o    (done_o),
        .err_o     (err_o),
        .ls_res_o  (ls_res_o),
        .psel_o    (psel),
        .penable_o (penable),
        .pwrite_o  (pwrite),
        .paddr_o   (paddr),
        .pwdata_o  (pwdata),
        .pstrb_o   (pstrb),
        .prdata_i  (prdata),
        .pready_i  (pready),
        .pslverr_i (pslverr)
    );

    apb_data_ram u_apb_data_ram (
        .clk       (clk),
        .arst_n_i  (arst_n_i),
        .psel_i    (psel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .paddr_i   (paddr),
        .pwdata_i  (pwdata),
        .pstrb_i   (pstrb),
        .prdata_o  (prdata),
        .pready_o  (pready),
        .pslverr_o (pslverr)
    );

endmodule

`default_nettype wire

/* tb_lsu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lsu_top;

    localparam int CLK_HALF   = 2;
    localparam int RST_CYCLES = 16;
    // full 7-bit major opcodes of rv64
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;
    // addi x0, x0, 0 and addi x5, x0, 1
    localparam lsu_pkg::inst_t NOP     = 32'h0000_0013;
    localparam lsu_pkg::inst_t ADDI_X5 = 32'h0010_0293;

    // one request with its expected completion
    typedef struct packed {
        lsu_pkg::inst_t instr;
        lsu_pkg::inst_t instr_last;
        lsu_pkg::xlen_t addr;
        lsu_pkg::xlen_t rs2;
        lsu_pkg::xlen_t wb_data;
        lsu_pkg::xlen_t exp_res;
        logic           exp_err;
    } entry_t;

    logic           clk;
    logic           arst_n_i;
    logic           valid_i;
    logic           ready_o;
    lsu_pkg::inst_t instr_i;
    lsu_pkg::inst_t instr_last_i;
    lsu_pkg::xlen_t addr_i;
    lsu_pkg::xlen_t rs2_i;
    lsu_pkg::xlen_t wb_data_i;
    logic           done_o;
    logic           err_o;
    lsu_pkg::xlen_t ls_res_o;

    entry_t         table_q[$];
    // byte image of the ram as the requests should leave it
    logic [7:0]     shadow [lsu_pkg::RAM_WORDS*8];
    logic [31:0]    lcg_state;
    logic           table_built = 1'b0;
    int             cur;

    lsu_top u_lsu_top (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .valid_i      (valid_i),
        .ready_o      (ready_o),
        .instr_i      (instr_i),
        .instr_last_i (instr_last_i),
        .addr_i       (addr_i),
        .rs2_i        (rs2_i),
        .wb_data_i    (wb_data_i),
        .done_o       (done_o),
        .err_o        (err_o),
        .ls_res_o     (ls_res_o)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // numerical recipes lcg
    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic lsu_pkg::xlen_t rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi        = lcg_next(lcg_state);
        lo        = lcg_next(hi);
        lcg_state = lo;
        return {hi, lo};
    endfunction

    // i-type load from x1 with zero offset
    function automatic lsu_pkg::inst_t enc_load(input logic [2:0] f3, input logic [4:0] rd);
        return {12'd0, 5'd1, f3, rd, OP_LOAD};
    endfunction

    // s-type store to x1 with zero offset
    function automatic lsu_pkg::inst_t enc_store(input logic [2:0] f3, input logic [4:0] rs2);
        return {7'd0, rs2, 5'd1, f3, 5'd0, OP_STORE};
    endfunction

    // expected result from rv64 load/store rules over the shadow image
    task automatic add_entry(input lsu_pkg::inst_t instr, input lsu_pkg::inst_t last,
                             input lsu_pkg::xlen_t addr, input lsu_pkg::xlen_t rs2);
        entry_t         e;
        logic           is_ld;
        logic           is_st;
        logic           bad;
        logic [2:0]     f3;
        int             nbytes;
        int             base;
        lsu_pkg::xlen_t data;
        lsu_pkg::xlen_t res;
        e.instr      = instr;
        e.instr_last = last;
        e.addr       = addr;
        e.rs2        = rs2;
        e.wb_data    = rand64();
        is_ld        = (instr[6:0] == OP_LOAD);
        is_st        = (instr[6:0] == OP_STORE);
        f3           = instr[14:12];
        nbytes       = 1 << f3[1:0];
        // needs natural alignment and a defined width inside the ram
        bad = !(is_ld || is_st) || ((addr & lsu_pkg::xlen_t'(nbytes - 1)) != '0)
            || (is_st && f3[2]) || (is_ld && (f3 == 3'b111))
            || (addr >= lsu_pkg::RAM_BYTES);
        // rd of an older load still in flight comes from write-back
        if ((last[6:0] == OP_LOAD) && (last[11:7] == instr[24:20])) begin
            data = e.wb_data;
        end else begin
            data = rs2;
        end
        res  = '0;
        base = int'(addr[10:0]);
        if (!bad) begin
            for (int i = 0; i < nbytes; i++) begin
                if (is_st) begin
                    shadow[base+i] = data[8*i +: 8];
                end else begin
                    res[8*i +: 8] = shadow[base+i];
                end
            end
            // lb, lh, lw replicate the top bit
            if (is_ld && !f3[2] && (nbytes < 8) && res[8*nbytes-1]) begin
                res = res | ~((64'd1 << (8*nbytes)) - 64'd1);
            end
        end
        e.exp_res = res;
        e.exp_err = bad;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        // doubleword round trip
        add_entry(enc_store(lsu_pkg::MEMOP_D, 5'd7), NOP, 64'h100, rand64());
        add_entry(enc_load(lsu_pkg::MEMOP_D, 5'd8), NOP, 64'h100, '0);
        // narrow stores merging into one doubleword
        add_entry(enc_store(lsu_pkg::MEMOP_D, 5'd7), NOP, 64'h200, rand64());
        add_entry(enc_store(lsu_pkg::MEMOP_D, 5'd7), NOP, 64'h208, rand64());
        add_entry(enc_store(lsu_pkg::MEMOP_B, 5'd7), NOP, 64'h203, rand64() | 64'h80);
        add_entry(enc_store(lsu_pkg::MEMOP_B, 5'd7), NOP, 64'h201, rand64() & ~64'h80);
        add_entry(enc_store(lsu_pkg::MEMOP_H, 5'd7), NOP, 64'h206, rand64() | 64'h8000);
        add_entry(enc_store(lsu_pkg::MEMOP_W, 5'd7), NOP, 64'h20c, rand64() | 64'h8000_0000);
        add_entry(enc_load(lsu_pkg::MEMOP_D, 5'd8), NOP, 64'h200, '0);
        add_entry(enc_load(lsu_pkg::MEMOP_D, 5'd8), NOP, 64'h208, '0);
        // every load width with both signs
        add_entry(enc_load(lsu_pkg::MEMOP_B, 5'd8), NOP, 64'h203, '0);
        add_entry(enc_load(lsu_pkg::MEMOP_BU, 5'd8), NOP, 64'h203, '0);
        add_entry(enc_load(lsu_pkg::MEMOP_B, 5'd8), NOP, 64'h201, '0);
        add_entry(enc_load(lsu_pkg::MEMOP_H, 5'd8), NOP, 64'h206, '0);
        add_entry(enc_load(lsu_pkg::MEMOP_HU, 5'd8), NOP, 64'h206, '0);
        add_entry(enc_load(lsu_pkg::MEMOP_H, 5'd8), NOP, 64'h202, '0);
        add_entry(enc_load(lsu_pkg::MEMOP_W, 5'd8), NOP, 64'h20c, '0);
        add_entry(enc_load(lsu_pkg::MEMOP_WU, 5'd8), NOP, 64'h20c, '0);
        add_entry(enc_load(lsu_pkg::MEMOP_W, 5'd8), NOP, 64'h200, '0);
        add_entry(enc_load(lsu_pkg::MEMOP_WU, 5'd8), NOP, 64'h204, '0);
        // load-to-store forwarding hit and near misses
        add_entry(enc_store(lsu_pkg::MEMOP_D, 5'd5), enc_load(lsu_pkg::MEMOP_D, 5'd5),
                  64'h300, rand64());
        add_entry(enc_load(lsu_pkg::MEMOP_D, 5'd9), NOP, 64'h300, '0);
        add_entry(enc_store(lsu_pkg::MEMOP_W, 5'd5), enc_load(lsu_pkg::MEMOP_W, 5'd6),
                  64'h308, rand64());
        add_entry(enc_store(lsu_pkg::MEMOP_H, 5'd5), ADDI_X5, 64'h30e, rand64());
        add_entry(enc_load(lsu_pkg::MEMOP_D, 5'd9), NOP, 64'h308, '0);
        // misaligned and illegal requests leave memory alone
        add_entry(enc_store(lsu_pkg::MEMOP_D, 5'd7), NOP, 64'h400, rand64());
        add_entry(enc_store(lsu_pkg::MEMOP_H, 5'd7), NOP, 64'h401, rand64());
        add_entry(enc_store(lsu_pkg::MEMOP_W, 5'd7), NOP, 64'h402, rand64());
        add_entry(enc_store(lsu_pkg::MEMOP_D, 5'd7), NOP, 64'h404, rand64());
        add_entry(enc_load(lsu_pkg::MEMOP_D, 5'd8), NOP, 64'h403, '0);
        add_entry(enc_load(lsu_pkg::MEMOP_W, 5'd8), NOP, 64'h406, '0);
        add_entry(enc_load(lsu_pkg::MEMOP_HU, 5'd8), NOP, 64'h405, '0);
        add_entry(ADDI_X5, NOP, 64'h400, rand64());
        add_entry(enc_store(3'b100, 5'd7), NOP, 64'h400, rand64());
        add_entry(enc_load(3'b111, 5'd8), NOP, 64'h400, '0);
        add_entry(enc_load(lsu_pkg::MEMOP_D, 5'd8), NOP, 64'h400, '0);
        // beyond the ram the aliased index stays untouched
        add_entry(enc_store(lsu_pkg::MEMOP_D, 5'd7), NOP, 64'h010, rand64());
        add_entry(enc_store(lsu_pkg::MEMOP_D, 5'd7), NOP, 64'h810, rand64());
        add_entry(enc_store(lsu_pkg::MEMOP_B, 5'd7), NOP, 64'h1000_0010, rand64());
        add_entry(enc_load(lsu_pkg::MEMOP_D, 5'd8), NOP, 64'h810, '0);
        add_entry(enc_load(lsu_pkg::MEMOP_D, 5'd8), NOP, 64'h010, '0);
        // top doubleword is still in range
        add_entry(enc_store(lsu_pkg::MEMOP_D, 5'd7), NOP, 64'h7f8, rand64());
        add_entry(enc_load(lsu_pkg::MEMOP_D, 5'd8), NOP, 64'h7f8, '0);
    endtask

    task automatic check_xlen(input string name, input lsu_pkg::xlen_t got,
                              input lsu_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("Mismatch %s (entry %0d): got 0x%h, expected 0x%h", name, cur, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch %s (entry %0d): got 0x%h, expected 0x%h", name, cur, got, exp);
            $display("TEST FAILED");
            $fatal(1, "stopping at first error");
        end
    endtask

    // starts and ends on a falling edge
    task automatic apply_entry(input entry_t e);
        instr_i      = e.instr;
        instr_last_i = e.instr_last;
        addr_i       = e.addr;
        rs2_i        = e.rs2;
        wb_data_i    = e.wb_data;
        valid_i      = 1'b1;
        while (!ready_o) begin
            @(negedge clk);
        end
        // accepted on this edge
        @(posedge clk);
        @(negedge clk);
        valid_i = 1'b0;
        // whole request must already be captured by now
        instr_i      = ~e.instr;
        instr_last_i = ~e.instr_last;
        addr_i       = ~e.addr;
        rs2_i        = ~e.rs2;
        wb_data_i    = ~e.wb_data;
        while (!done_o) begin
            @(negedge clk);
        end
        check_flag("ready_o", ready_o, 1'b0);
        check_flag("err_o", err_o, e.exp_err);
        check_xlen("ls_res_o", ls_res_o, e.exp_res);
        // one-cycle done pulse before idle again
        @(negedge clk);
        check_flag("done_o", done_o, 1'b0);
        check_flag("ready_o", ready_o, 1'b1);
    endtask

    initial begin
        arst_n_i     = 1'b0;
        valid_i      = 1'b0;
        instr_i      = NOP;
        instr_last_i = NOP;
        addr_i       = '0;
        rs2_i        = '0;
        wb_data_i    = '0;
        cur          = -1;
        lcg_state    = 32'hc494;
        // ram comes out of reset zeroed
        foreach (shadow[i]) begin
            shadow[i] = 8'h00;
        end
        build_table();
        table_built = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;
        @(negedge clk);
        check_flag("ready_o", ready_o, 1'b1);
        check_flag("done_o", done_o, 1'b0);
        check_flag("err_o", err_o, 1'b0);
        foreach (table_q[i]) begin
            cur = i;
            apply_entry(table_q[i]);
        end
        $display("TEST OK");
        $finish;
    end

    // eight cycles per entry against four for a legal access
    initial begin
        wait (table_built);
        repeat (RST_CYCLES + 4 + table_q.size() * 8) @(posedge clk);
        $display("timeout: done_o never arrived, stuck at entry %0d", cur);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire
